// File: hw/stream_pkg.sv
// Stream combiner shared types
`default_nettype none

package stream_pkg;

    // Number of converter channels merged onto the output stream
    localparam int num_channels = 3;

    // Widths that carry a meaning on the input and output streams
    typedef logic signed [15:0] sample_t;
    typedef logic [7:0] dest_t;
    typedef logic [7:0] user_t;
    typedef logic [31:0] word_t;

    // Channel index and per-channel frame position
    typedef logic [$clog2(num_channels)-1:0] channel_t;
    typedef logic [15:0] count_t;

    // Payload of one input beat, 32 bits
    typedef struct packed {
        sample_t sample;
        dest_t   dest;
        user_t   user;
    } in_beat_t;

    // Payload of one output beat, 49 bits
    typedef struct packed {
        word_t data;
        dest_t dest;
        user_t user;
        logic  last;
    } out_beat_t;

endpackage

`default_nettype wire

// File: hw/channel_arbiter.sv
// Fixed-priority channel arbiter
`default_nettype none

module channel_arbiter
    import stream_pkg::*;
(
    input  logic [num_channels-1:0]     in_valid,
    input  in_beat_t [num_channels-1:0] in_beat,
    input  logic                        load,
    output logic [num_channels-1:0]     in_ready,
    output logic                        accept,
    output channel_t                    channel,
    output in_beat_t                    beat
);

    // Bit k is set when any channel below k has a valid beat
    logic [num_channels-1:0] lower_valid;
    // One-hot mark of the winning channel
    logic [num_channels-1:0] grant;

    // Channel 0 has nothing above it, so it never waits
    always_comb begin
        lower_valid[0] = 1'b0;
        for (int k = 1; k < num_channels; k++) begin
            lower_valid[k] = lower_valid[k-1] | in_valid[k-1];
        end
    end

    // The lowest valid channel is the only one not masked by a lower one
    assign grant = in_valid & ~lower_valid;

    // A channel may only transfer when the output register can take the beat
    // and no lower-numbered channel is competing for it
    assign in_ready = {num_channels{load}} & ~lower_valid;

    // Exactly one transfer happens whenever some channel is valid and load is high
    assign accept = load & (|in_valid);

    // Encode the one-hot grant into a channel index
    always_comb begin
        channel = '0;
        for (int k = 0; k < num_channels; k++) begin
            if (grant[k]) begin
                channel = channel_t'(k);
            end
        end
    end

    // Payload of the winner, only meaningful while accept is high
    assign beat = in_beat[channel];

endmodule

`default_nettype wire

// File: hw/frame_counter.sv
// Per-channel frame counter
`default_nettype none

module frame_counter
    import stream_pkg::*;
#(
    parameter int FRAME_LENGTH = 1024
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     accept,
    input  channel_t channel,
    output logic     last
);

    // Count value held by a channel just before its frame-ending beat
    localparam count_t last_count = count_t'(FRAME_LENGTH - 1);

    // One counter of accepted beats per channel
    count_t counters [num_channels];

    // The beat being accepted closes the frame when its channel is at the
    // final position, so each channel frames on its own traffic only
    assign last = accept && (counters[channel] == last_count);

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int k = 0; k < num_channels; k++) begin
                counters[k] <= '0;
            end
        end else if (accept) begin
            // Only the winning channel moves; the others keep their position
            if (last) begin
                counters[channel] <= '0;
            end else begin
                counters[channel] <= counters[channel] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/word_formatter.sv
// Output word formatter and holding register
`default_nettype none

module word_formatter
    import stream_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      accept,
    input  in_beat_t  beat,
    input  logic      last,
    input  logic      out_ready,
    output logic      load,
    output logic      out_valid,
    output out_beat_t out_beat
);

    // Bits between the tag and the sample that repeat the sign
    localparam int fill_width = $bits(word_t) - $bits(sample_t) - $bits(dest_t);

    // Formatted beat presented to the register on accept
    out_beat_t next_beat;

    // Tag in the top byte, sign fill below it, sample in the low half
    always_comb begin
        next_beat.data = {
            beat.dest,
            {fill_width{beat.sample[$bits(sample_t)-1]}},
            beat.sample
        };
        next_beat.dest = beat.dest;
        next_beat.user = beat.user;
        next_beat.last = last;
    end

    // The register can take a new beat when it is empty or being drained
    // at this edge, which keeps full throughput under a ready sink
    assign load = !out_valid || out_ready;

    // Valid flag of the single-entry register
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload only changes on accept, so a held beat survives back-pressure
    always_ff @(posedge clock) begin
        if (accept) begin
            out_beat <= next_beat;
        end
    end

endmodule

`default_nettype wire

// File: hw/stream_combiner_top.sv
// Three-channel stream combiner
`default_nettype none

module stream_combiner_top
    import stream_pkg::*;
#(
    parameter int FRAME_LENGTH = 1024
) (
    input  logic                        clock,
    input  logic                        reset,

    // Converter channel streams
    input  logic [num_channels-1:0]     in_valid,
    input  in_beat_t [num_channels-1:0] in_beat,
    output logic [num_channels-1:0]     in_ready,

    // Merged word stream
    output logic                        out_valid,
    output out_beat_t                   out_beat,
    input  logic                        out_ready
);

    // Output register can take a beat this cycle
    logic     load;

    // One-cycle pulse for the single input transfer of this cycle
    logic     accept;

    // Winning channel and its payload
    channel_t channel;
    in_beat_t beat;

    // The accepted beat closes a frame on its channel
    logic     last;

    // Pick the lowest valid channel and hand out ready
    channel_arbiter arbiter_i (
        .in_valid (in_valid),
        .in_beat  (in_beat),
        .load     (load),
        .in_ready (in_ready),
        .accept   (accept),
        .channel  (channel),
        .beat     (beat)
    );

    // Count accepted beats per channel and flag frame ends
    frame_counter #(
        .FRAME_LENGTH (FRAME_LENGTH)
    ) counter_i (
        .clock   (clock),
        .reset   (reset),
        .accept  (accept),
        .channel (channel),
        .last    (last)
    );

    // Pack the output word and hold it until the sink takes it
    word_formatter formatter_i (
        .clock     (clock),
        .reset     (reset),
        .accept    (accept),
        .beat      (beat),
        .last      (last),
        .out_ready (out_ready),
        .load      (load),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

endmodule

`default_nettype wire

// File: test/clock_gen.sv
// Testbench clock and reset
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Reset is active low and released just after the 8th rising edge
    initial begin
        reset = 1'b0;
        repeat (8) @(posedge clock);
        #1 reset = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/stream_combiner_tb.sv
// Stream combiner testbench
`default_nettype none

module stream_combiner_tb
    import stream_pkg::*;
();

    localparam int frame_length = 4;
    // Cycles per test: reset, reset check, packing, priority, back-pressure, frame, random
    localparam int cycle_budget = 8 + 2 + 10 + 10 + 20 + 60 + 310;
    localparam int timeout_time = cycle_budget * 4 + 200;

    logic                        clock;
    logic                        reset;
    logic [num_channels-1:0]     in_valid;
    in_beat_t [num_channels-1:0] in_beat;
    logic [num_channels-1:0]     in_ready;
    logic                        out_valid;
    out_beat_t                   out_beat;
    logic                        out_ready;

    // Reference model state
    out_beat_t expected_q [$];
    int        model_count [num_channels];
    int        accepted = 0;
    int        delivered = 0;
    int        seed = 29343;

    clock_gen clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    stream_combiner_top #(
        .FRAME_LENGTH (frame_length)
    ) dut_i (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    task automatic compare(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR: time %0t, %s: got %h, expected %h", $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic in_beat_t make_beat(input sample_t sample, input dest_t dest,
                                           input user_t user);
        in_beat_t b;
        b.sample = sample;
        b.dest = dest;
        b.user = user;
        return b;
    endfunction

    // Tag on top, eight copies of the sign bit, then the sample
    function automatic out_beat_t format_beat(input in_beat_t b, input logic last);
        out_beat_t o;
        o.data[31:24] = b.dest;
        o.data[23:16] = b.sample[15] ? 8'hFF : 8'h00;
        o.data[15:0] = b.sample;
        o.dest = b.dest;
        o.user = b.user;
        o.last = last;
        return o;
    endfunction

    // Model step at the falling edge, where every signal is stable; it checks
    // the outputs and predicts the transfers of the coming rising edge
    always @(negedge clock) begin : model_step
        logic [num_channels-1:0] exp_ready;
        logic                    lower;
        logic                    exp_load;
        int                      winner;
        if (reset) begin
            exp_load = (expected_q.size() == 0) || out_ready;
            lower = 1'b0;
            winner = -1;
            for (int k = 0; k < num_channels; k++) begin
                exp_ready[k] = exp_load && !lower;
                if (in_valid[k] && !lower) begin
                    winner = k;
                end
                lower = lower | in_valid[k];
            end
            compare("in_ready", in_ready, exp_ready);
            compare("out_valid", out_valid, expected_q.size() != 0);
            if (expected_q.size() != 0) begin
                compare("out_beat", out_beat, expected_q[0]);
                if (out_ready) begin
                    void'(expected_q.pop_front());
                    delivered++;
                end
            end
            if (exp_load && winner >= 0) begin
                expected_q.push_back(format_beat(in_beat[winner],
                                                 model_count[winner] == frame_length - 1));
                if (model_count[winner] == frame_length - 1) begin
                    model_count[winner] = 0;
                end else begin
                    model_count[winner] = model_count[winner] + 1;
                end
                accepted++;
            end
        end
    end

    // Holds one channel valid until its handshake, then drops it
    task automatic send(input int ch, input in_beat_t b);
        in_beat[ch] = b;
        in_valid[ch] = 1'b1;
        @(negedge clock);
        while (!in_ready[ch]) @(negedge clock);
        @(posedge clock);
        #1;
        in_valid[ch] = 1'b0;
    endtask

    // Keeps each valid channel up until its own handshake
    task automatic run_pending();
        logic [num_channels-1:0] taken;
        while (in_valid != '0) begin
            @(negedge clock);
            taken = in_valid & in_ready;
            @(posedge clock);
            #1;
            in_valid = in_valid & ~taken;
        end
    endtask

    task automatic drain();
        out_ready = 1'b1;
        run_pending();
        @(negedge clock);
        while (out_valid) @(negedge clock);
        @(posedge clock);
        #1;
    endtask

    task automatic reset_values();
        @(negedge clock);
        compare("out_valid after reset", out_valid, 0);
        compare("in_ready after reset", in_ready, 3'b111);
        @(posedge clock);
        #1;
    endtask

    task automatic packed_words();
        out_ready = 1'b1;
        send(1, make_beat(16'sh1234, 8'h3C, 8'h5A));
        @(negedge clock);
        compare("out_valid", out_valid, 1);
        compare("out_beat.data", out_beat.data, 32'h3C001234);
        compare("out_beat.dest", out_beat.dest, 8'h3C);
        compare("out_beat.user", out_beat.user, 8'h5A);
        @(posedge clock);
        #1;
        send(2, make_beat(-16'sd2, 8'hC3, 8'h11));
        @(negedge clock);
        compare("out_beat.data", out_beat.data, 32'hC3FFFFFE);
        compare("out_beat.dest", out_beat.dest, 8'hC3);
        compare("out_beat.user", out_beat.user, 8'h11);
        @(posedge clock);
        #1;
        drain();
    endtask

    task automatic channel_priority();
        logic [num_channels-1:0] taken;
        out_ready = 1'b1;
        for (int k = 0; k < num_channels; k++) begin
            in_beat[k] = make_beat(sample_t'(16'h0100 * (k + 1)), dest_t'(8'h10 + k),
                                   user_t'(k));
        end
        in_valid = '1;
        for (int r = 0; r < num_channels; r++) begin
            @(negedge clock);
            if (r > 0) begin
                compare("out_beat.dest in order", out_beat.dest, 8'h10 + r - 1);
            end
            taken = in_valid & in_ready;
            compare("granted channel", taken, 1 << r);
            @(posedge clock);
            #1;
            in_valid = in_valid & ~taken;
        end
        @(negedge clock);
        compare("out_beat.dest in order", out_beat.dest, 8'h12);
        @(posedge clock);
        #1;
        drain();
    endtask

    task automatic held_under_stall();
        out_beat_t               held;
        logic [num_channels-1:0] taken;
        int                      delivered_before;
        delivered_before = delivered;
        out_ready = 1'b0;
        in_beat[0] = make_beat(16'sh7F00, 8'h20, 8'hA0);
        in_beat[2] = make_beat(-16'sd300, 8'h22, 8'hA2);
        in_valid = 3'b101;
        @(negedge clock);
        taken = in_valid & in_ready;
        compare("first taken", taken, 3'b001);
        @(posedge clock);
        #1;
        in_valid = in_valid & ~taken;
        @(negedge clock);
        held = out_beat;
        compare("held data", held.data, 32'h20007F00);
        repeat (6) begin
            compare("out_valid held", out_valid, 1);
            compare("out_beat held", out_beat, held);
            compare("in_ready stalled", in_ready, 0);
            @(negedge clock);
        end
        @(posedge clock);
        #1;
        drain();
        compare("beats delivered", delivered - delivered_before, 2);
    endtask

    task automatic frame_marking();
        int seen [num_channels];
        int ch;
        out_ready = 1'b1;
        for (int k = 0; k < num_channels; k++) begin
            seen[k] = model_count[k];
        end
        for (int i = 0; i < 27; i++) begin
            ch = (i + i / 4) % num_channels;
            send(ch, make_beat(sample_t'(i * 1111 - 15000), dest_t'(8'h40 + ch), user_t'(i)));
            seen[ch] = seen[ch] + 1;
            @(negedge clock);
            compare("out_beat.last", out_beat.last, seen[ch] % frame_length == 0);
            @(posedge clock);
            #1;
        end
        drain();
    endtask

    task automatic random_traffic();
        logic [num_channels-1:0] taken;
        int                      start;
        start = accepted;
        for (int c = 0; c < 300; c++) begin
            @(negedge clock);
            taken = in_valid & in_ready;
            @(posedge clock);
            #1;
            in_valid = in_valid & ~taken;
            for (int k = 0; k < num_channels; k++) begin
                if (!in_valid[k] && (($random(seed) & 3) != 0)) begin
                    in_beat[k] = $random(seed);
                    in_valid[k] = 1'b1;
                end
            end
            out_ready = ($random(seed) & 3) != 0;
        end
        drain();
        compare("random beats accepted", (accepted - start) > 100, 1);
    endtask

    initial begin : watchdog
        #(timeout_time);
        $display("TIMEOUT: the tests did not finish within %0d time units", timeout_time);
        $display("Verification failed");
        $fatal(1, "run stopped by the watchdog");
    end

    initial begin
        in_valid = '0;
        in_beat = '0;
        out_ready = 1'b0;
        for (int k = 0; k < num_channels; k++) begin
            model_count[k] = 0;
        end
        wait (reset === 1'b1);
        @(posedge clock);
        #1;
        reset_values();
        packed_words();
        channel_priority();
        held_under_stall();
        frame_marking();
        random_traffic();
        compare("beats accepted versus delivered", accepted, delivered);
        compare("model entries left", expected_q.size(), 0);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: stream_combiner.f
hw/stream_pkg.sv
hw/channel_arbiter.sv
hw/frame_counter.sv
hw/word_formatter.sv
hw/stream_combiner_top.sv
test/clock_gen.sv
test/stream_combiner_tb.sv

// File: Bender.yml
package:
  name: stream_combiner

sources:
  - hw/stream_pkg.sv
  - hw/channel_arbiter.sv
  - hw/frame_counter.sv
  - hw/word_formatter.sv
  - hw/stream_combiner_top.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/stream_combiner_tb.sv
